/* core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Register file size, r0 reads as zero
`define CORE_REG_COUNT 16

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// Stores here go to io_valid/io_data
`define CORE_IO_BUS_ADDR 32'h0000_0FFC

`define CORE_XLEN 32

`endif

/* mem_pkg.sv */
`include "core_settings.svh"

package mem_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;

    // Byte address, word aligned
    typedef logic [`CORE_XLEN-1:0] addr_t;

    typedef enum logic {
        ACC_READ,
        ACC_WRITE
    } access_t;

endpackage

/* isa_pkg.sv */
`include "core_settings.svh"

package isa_pkg;

    // Unlisted codes execute as a no-op
    typedef enum logic [5:0] {
        OP_ADD    = 6'h01,
        OP_SUB    = 6'h02,
        OP_ADDI   = 6'h03,
        OP_LW     = 6'h04,
        OP_SW     = 6'h05,
        OP_BNE    = 6'h06,
        OP_EBREAK = 6'h3f
    } opcode_t;

    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_idx_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [13:0] unused;
    } r_fmt_t;

    // SW and BNE read rd as a source
    typedef struct packed {
        opcode_t            opcode;
        reg_idx_t           rd;
        reg_idx_t           rs1;
        logic signed [17:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

endpackage

/* core_ifs.sv */
`timescale 1ns/10ps

// Four-phase req/ack port
interface mem_port_if;
    logic              req;
    logic              ack;
    mem_pkg::access_t  access;
    mem_pkg::addr_t    addr;
    mem_pkg::word_t    wdata;
    mem_pkg::word_t    rdata;

    modport requester (output req, access, addr, wdata, input ack, rdata);
    modport responder (input req, access, addr, wdata, output ack, rdata);
endinterface

// Held until go, transfer on valid && go
interface issue_if;
    logic             valid;
    isa_pkg::instr_t  instr;
    mem_pkg::addr_t   pc;
    logic             go;

    modport source (output valid, instr, pc, input go);
    modport sched (input valid, instr, output go);
    modport sink (input valid, instr, pc, go);
endinterface

// Scoreboard set and clear
interface wb_if;
    logic               load_issue;
    isa_pkg::reg_idx_t  load_rd;
    logic               load_done;
    isa_pkg::reg_idx_t  done_rd;

    modport source (output load_issue, load_rd, load_done, done_rd);
    modport sink (input load_issue, load_rd, load_done, done_rd);
endinterface

/* front_end.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module front_end (
    input  logic           clk,
    input  logic           reset,
    mem_port_if.requester  fetch_port,
    issue_if.source        issue,
    input  logic           redirect_valid,
    input  mem_pkg::addr_t redirect_pc,
    input  logic           halt
);
    mem_pkg::addr_t   pc_q;
    mem_pkg::addr_t   fetch_addr_q;
    mem_pkg::addr_t   held_pc_q;
    isa_pkg::instr_t  held_instr_q;
    logic             req_q;
    logic             valid_q;
    logic             stale_q;
    logic             halted_q;
    logic             transfer;
    logic             stop_after;
    logic             capture;
    logic             start_fetch;
    mem_pkg::addr_t   next_addr;

    assign transfer = issue.valid && issue.go;
    // Nothing is fetched past an EBREAK
    assign stop_after = transfer && (held_instr_q.r.opcode == isa_pkg::OP_EBREAK);
    assign capture = req_q && fetch_port.ack;
    assign start_fetch = !req_q && !fetch_port.ack && (!valid_q || transfer)
                      && !halted_q && !halt && !stop_after;
    assign next_addr = redirect_valid ? redirect_pc : pc_q;

    assign fetch_port.req = req_q;
    assign fetch_port.access = mem_pkg::ACC_READ;
    assign fetch_port.addr = fetch_addr_q;
    assign fetch_port.wdata = '0;

    // Held word is stale during a redirect
    assign issue.valid = valid_q && !redirect_valid;
    assign issue.instr = held_instr_q;
    assign issue.pc = held_pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `CORE_RESET_PC;
            req_q <= 1'b0;
            valid_q <= 1'b0;
            stale_q <= 1'b0;
            halted_q <= 1'b0;
        end else begin
            halted_q <= halted_q || halt || stop_after;
            if (start_fetch) begin
                req_q <= 1'b1;
                pc_q <= next_addr + 32'd4;
            end else if (redirect_valid) begin
                pc_q <= redirect_pc;
            end
            if (capture) begin
                req_q <= 1'b0;
                stale_q <= 1'b0;
            end else if (redirect_valid && req_q) begin
                stale_q <= 1'b1;
            end
            // Stale fetch finishes its handshake, then is dropped
            if (capture && !stale_q && !redirect_valid) begin
                valid_q <= 1'b1;
            end else if (transfer || redirect_valid) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_fetch) begin
            fetch_addr_q <= next_addr;
        end
        if (capture) begin
            held_instr_q <= fetch_port.rdata;
            held_pc_q <= fetch_addr_q;
        end
    end

endmodule

/* scheduler.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module scheduler (
    input  logic    clk,
    input  logic    reset,
    issue_if.sched  issue,
    wb_if.sink      wb,
    input  logic    mem_busy
);
    logic [`CORE_REG_COUNT-1:0]  pending_q;
    isa_pkg::opcode_t            op;
    logic                        reg_hit;
    logic                        mem_hold;
    logic                        drain_hold;

    assign op = issue.instr.r.opcode;

    // rs2 is a register only in the R format
    assign reg_hit = pending_q[issue.instr.r.rd] || pending_q[issue.instr.r.rs1]
                  || ((op == isa_pkg::OP_ADD || op == isa_pkg::OP_SUB)
                      && pending_q[issue.instr.r.rs2]);

    assign mem_hold = (op == isa_pkg::OP_LW || op == isa_pkg::OP_SW) && mem_busy;

    // Halt only once loads and stores have drained
    assign drain_hold = (op == isa_pkg::OP_EBREAK) && ((|pending_q) || mem_busy);

    assign issue.go = issue.valid && !reg_hit && !mem_hold && !drain_hold;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= '0;
        end else begin
            if (wb.load_done) begin
                pending_q[wb.done_rd] <= 1'b0;
            end
            if (wb.load_issue) begin
                pending_q[wb.load_rd] <= 1'b1;
            end
        end
    end

endmodule

/* back_end.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module back_end (
    input  logic           clk,
    input  logic           reset,
    issue_if.sink          issue,
    wb_if.source           wb,
    mem_port_if.requester  data_port,
    output logic           redirect_valid,
    output mem_pkg::addr_t redirect_pc,
    output logic           mem_busy,
    output logic           halt,
    output logic           ebreak
);
    mem_pkg::word_t     regs [`CORE_REG_COUNT];
    isa_pkg::instr_t    instr;
    isa_pkg::opcode_t   op;
    mem_pkg::word_t     rd_val;
    mem_pkg::word_t     rs1_val;
    mem_pkg::word_t     rs2_val;
    mem_pkg::word_t     imm;
    mem_pkg::word_t     alu_result;
    logic               transfer;
    logic               alu_we;
    logic               launch;
    logic               mem_req_q;
    logic               mem_write_q;
    mem_pkg::addr_t     mem_addr_q;
    mem_pkg::word_t     mem_wdata_q;
    isa_pkg::reg_idx_t  ld_rd_q;
    mem_pkg::word_t     ld_data_q;
    logic               ld_pending_q;
    logic               ld_return;
    logic               ld_avail;
    logic               ld_write;
    logic               halt_q;

    assign instr = issue.instr;
    assign op = instr.r.opcode;
    assign transfer = issue.valid && issue.go;

    assign rd_val = (instr.r.rd == '0) ? '0 : regs[instr.r.rd];
    assign rs1_val = (instr.r.rs1 == '0) ? '0 : regs[instr.r.rs1];
    assign rs2_val = (instr.r.rs2 == '0) ? '0 : regs[instr.r.rs2];
    assign imm = {{(`CORE_XLEN-18){instr.i.imm[17]}}, instr.i.imm};

    // Default sum doubles as the LW/SW address
    always_comb begin
        case (op)
            isa_pkg::OP_ADD: alu_result = rs1_val + rs2_val;
            isa_pkg::OP_SUB: alu_result = rs1_val - rs2_val;
            default:         alu_result = rs1_val + imm;
        endcase
    end

    assign alu_we = transfer && (instr.r.rd != '0)
                 && (op inside {isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_ADDI});
    assign launch = transfer && (op == isa_pkg::OP_LW || op == isa_pkg::OP_SW);

    // Load return waits behind an ALU write
    assign ld_return = mem_req_q && data_port.ack && !mem_write_q;
    assign ld_avail = ld_return || ld_pending_q;
    assign ld_write = ld_avail && !alu_we;

    assign data_port.req = mem_req_q;
    assign data_port.access = mem_write_q ? mem_pkg::ACC_WRITE : mem_pkg::ACC_READ;
    assign data_port.addr = mem_addr_q;
    assign data_port.wdata = mem_wdata_q;

    assign wb.load_issue = transfer && (op == isa_pkg::OP_LW);
    assign wb.load_rd = instr.r.rd;
    assign wb.load_done = ld_write;
    assign wb.done_rd = ld_rd_q;

    assign mem_busy = mem_req_q || data_port.ack || ld_pending_q;
    assign halt = halt_q;
    assign ebreak = halt_q;

    always_ff @(posedge clk) begin
        if (alu_we) begin
            regs[instr.r.rd] <= alu_result;
        end else if (ld_write && ld_rd_q != '0) begin
            regs[ld_rd_q] <= ld_pending_q ? ld_data_q : data_port.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_valid <= 1'b0;
            mem_req_q <= 1'b0;
            ld_pending_q <= 1'b0;
            halt_q <= 1'b0;
        end else begin
            redirect_valid <= transfer && (op == isa_pkg::OP_BNE) && (rd_val != rs1_val);
            halt_q <= halt_q || (transfer && op == isa_pkg::OP_EBREAK);
            if (launch) begin
                mem_req_q <= 1'b1;
            end else if (mem_req_q && data_port.ack) begin
                mem_req_q <= 1'b0;
            end
            ld_pending_q <= ld_avail && alu_we;
        end
    end

    always_ff @(posedge clk) begin
        redirect_pc <= issue.pc + {imm[`CORE_XLEN-3:0], 2'b00};
        if (launch) begin
            mem_addr_q <= alu_result;
            mem_write_q <= (op == isa_pkg::OP_SW);
            mem_wdata_q <= rd_val;
            ld_rd_q <= instr.r.rd;
        end
        if (ld_return) begin
            ld_data_q <= data_port.rdata;
        end
    end

endmodule

/* mem_ctrl.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module mem_ctrl (
    input  logic           clk,
    input  logic           reset,
    mem_port_if.responder  fetch_port,
    mem_port_if.responder  data_port,
    output logic           i_req,
    output mem_pkg::addr_t i_addr,
    input  logic           i_ack,
    input  mem_pkg::word_t i_rdata,
    output logic           d_req,
    output logic           d_write,
    output mem_pkg::addr_t d_addr,
    output mem_pkg::word_t d_wdata,
    input  logic           d_ack,
    input  mem_pkg::word_t d_rdata,
    output logic           io_valid,
    output mem_pkg::word_t io_data
);
    logic            i_ack_q;
    logic            d_ack_q;
    logic            io_ack_q;
    logic            is_io;
    mem_pkg::word_t  i_rdata_q;
    mem_pkg::word_t  d_rdata_q;

    // IO bus stores are completed here and never reach the d port
    assign is_io = (data_port.access == mem_pkg::ACC_WRITE)
                && (data_port.addr == `CORE_IO_BUS_ADDR);

    assign fetch_port.ack = i_ack_q;
    assign fetch_port.rdata = i_rdata_q;
    assign data_port.ack = d_ack_q || io_ack_q;
    assign data_port.rdata = d_rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            i_req <= 1'b0;
            i_ack_q <= 1'b0;
            d_req <= 1'b0;
            d_ack_q <= 1'b0;
            io_ack_q <= 1'b0;
            io_valid <= 1'b0;
        end else begin
            i_req <= fetch_port.req;
            i_ack_q <= i_ack;
            d_req <= data_port.req && !is_io;
            d_ack_q <= d_ack;
            io_ack_q <= data_port.req && is_io;
            // One pulse, on the first cycle of the request
            io_valid <= data_port.req && is_io && !io_ack_q;
        end
    end

    always_ff @(posedge clk) begin
        i_addr <= fetch_port.addr;
        d_write <= (data_port.access == mem_pkg::ACC_WRITE);
        d_addr <= data_port.addr;
        d_wdata <= data_port.wdata;
        if (i_ack) begin
            i_rdata_q <= i_rdata;
        end
        if (d_ack) begin
            d_rdata_q <= d_rdata;
        end
        if (data_port.req && is_io && !io_ack_q) begin
            io_data <= data_port.wdata;
        end
    end

endmodule

/* scalar_core.sv */
`timescale 1ns/10ps

module scalar_core (
    // Clock
    input  wire                  clk,
    input  wire                  reset,

    // Instruction memory
    output wire                  i_req,
    input  wire                  i_ack,
    output wire mem_pkg::addr_t  i_addr,
    input  wire mem_pkg::word_t  i_rdata,

    // Data memory
    output wire                  d_req,
    input  wire                  d_ack,
    output wire                  d_write,
    output wire mem_pkg::addr_t  d_addr,
    output wire mem_pkg::word_t  d_wdata,
    input  wire mem_pkg::word_t  d_rdata,

    // IO
    output wire                  io_valid,
    output wire mem_pkg::word_t  io_data,

    output wire                  ebreak
);
    wire                  redirect_valid;
    wire mem_pkg::addr_t  redirect_pc;
    wire                  mem_busy;
    wire                  halt;

    mem_port_if  fetch_port();
    mem_port_if  data_port();
    issue_if     issue();
    wb_if        wb();

    front_end front_end (
        .clk             (clk),
        .reset           (reset),
        .fetch_port      (fetch_port),
        .issue           (issue),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .halt            (halt)
    );

    scheduler scheduler (
        .clk             (clk),
        .reset           (reset),
        .issue           (issue),
        .wb              (wb),
        .mem_busy        (mem_busy)
    );

    back_end back_end (
        .clk             (clk),
        .reset           (reset),
        .issue           (issue),
        .wb              (wb),
        .data_port       (data_port),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .mem_busy        (mem_busy),
        .halt            (halt),
        .ebreak          (ebreak)
    );

    mem_ctrl mem_ctrl (
        .clk             (clk),
        .reset           (reset),
        .fetch_port      (fetch_port),
        .data_port       (data_port),
        .i_req           (i_req),
        .i_addr          (i_addr),
        .i_ack           (i_ack),
        .i_rdata         (i_rdata),
        .d_req           (d_req),
        .d_write         (d_write),
        .d_addr          (d_addr),
        .d_wdata         (d_wdata),
        .d_ack           (d_ack),
        .d_rdata         (d_rdata),
        .io_valid        (io_valid),
        .io_data         (io_data)
    );

endmodule

/* scalar_core_checker.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module scalar_core_checker (
    input logic        clk,
    input logic        reset,
    input logic        i_req,
    input logic        i_ack,
    input logic [31:0] i_addr,
    input logic        d_req,
    input logic        d_ack,
    input logic [31:0] d_addr,
    input logic        io_valid
);

    a_reqs_low_after_reset: assert property (@(posedge clk) reset |=> !i_req && !d_req)
        else $error("req high after reset");

    // Ack still high from the last access
    a_i_req_waits_ack: assert property (@(posedge clk) disable iff (reset)
        !i_req && i_ack |=> !i_req)
        else $error("i_req rose while i_ack high");

    a_d_req_waits_ack: assert property (@(posedge clk) disable iff (reset)
        !d_req && d_ack |=> !d_req)
        else $error("d_req rose while d_ack high");

    a_i_addr_stable: assert property (@(posedge clk) disable iff (reset)
        i_req |=> !i_req || $stable(i_addr))
        else $error("i_addr changed while i_req high");

    a_d_addr_stable: assert property (@(posedge clk) disable iff (reset)
        d_req |=> !d_req || $stable(d_addr))
        else $error("d_addr changed while d_req high");

    a_io_single_pulse: assert property (@(posedge clk) disable iff (reset)
        io_valid |=> !io_valid)
        else $error("io_valid high for two cycles");

    a_no_io_on_d_port: assert property (@(posedge clk) disable iff (reset)
        d_req |-> d_addr != `CORE_IO_BUS_ADDR)
        else $error("IO address seen on d port");

endmodule

bind scalar_core scalar_core_checker core_checks (.*);

/* scalar_core_tb.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module scalar_core_tb;
    logic            clk;
    logic            reset;
    logic            i_req;
    logic            i_ack;
    mem_pkg::addr_t  i_addr;
    mem_pkg::word_t  i_rdata;
    logic            d_req;
    logic            d_ack;
    logic            d_write;
    mem_pkg::addr_t  d_addr;
    mem_pkg::word_t  d_wdata;
    mem_pkg::word_t  d_rdata;
    logic            io_valid;
    mem_pkg::word_t  io_data;
    logic            ebreak;

    logic [31:0]     gold [0:255];
    mem_pkg::word_t  imem [0:63];
    mem_pkg::word_t  dmem [0:1023];
    mem_pkg::word_t  io_exp [$];
    mem_pkg::addr_t  final_addr [$];
    mem_pkg::word_t  final_exp [$];
    int              prog_len;
    int              io_idx;
    int              mismatches;
    int              other_errors;
    int              cycles;
    int              timeout_limit;
    int              i_wait;
    int              d_wait;
    logic            ebreak_seen;
    logic            i_req_prev;

    scalar_core DUT (.*);

    always #50 clk = ~clk;

    task automatic check_io(input mem_pkg::word_t got, input mem_pkg::word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: io_data got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_mem(input mem_pkg::addr_t addr, input mem_pkg::word_t got,
                             input mem_pkg::word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: dmem[%h] got %h expected %h", $time, addr, got, exp);
        end
    endtask

    function automatic mem_pkg::word_t fetch_word(input mem_pkg::addr_t a);
        // Past the program end opcode 0 runs as a no-op
        if (a[31:2] < prog_len) begin
            return imem[a[7:2]];
        end
        return {6'h00, a[25:0] ^ a[31:6]};
    endfunction

    task automatic load_golden();
        int pos;
        int n_data;
        int n_io;
        int n_final;
        $readmemh("scalar_core_golden.txt", gold);
        prog_len = gold[0];
        n_data = gold[1];
        n_io = gold[2];
        n_final = gold[3];
        pos = 4;
        for (int i = 0; i < prog_len; i++) begin
            imem[i] = gold[pos];
            pos++;
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = 32'hA5C3_0000 ^ (i << 2);
        end
        for (int i = 0; i < n_data; i++) begin
            dmem[gold[pos][11:2]] = gold[pos+1];
            pos += 2;
        end
        for (int i = 0; i < n_io; i++) begin
            io_exp.push_back(gold[pos]);
            pos++;
        end
        for (int i = 0; i < n_final; i++) begin
            final_addr.push_back(gold[pos]);
            final_exp.push_back(gold[pos+1]);
            pos += 2;
        end
        timeout_limit = 40 * (prog_len + n_io) * 6;
    endtask

    // Instruction memory with random ack and release delays
    always @(negedge clk) begin
        if (i_req != i_ack) begin
            if (i_wait < 0) begin
                i_wait = $urandom % 5;
            end
            if (i_wait == 0) begin
                i_ack <= i_req;
                if (i_req) begin
                    i_rdata <= fetch_word(i_addr);
                end
                i_wait = -1;
            end else begin
                i_wait--;
            end
        end
    end

    // Data memory with random ack and release delays
    always @(negedge clk) begin
        if (d_req != d_ack) begin
            if (d_wait < 0) begin
                d_wait = $urandom % 5;
            end
            if (d_wait == 0) begin
                d_ack <= d_req;
                if (d_req && d_write) begin
                    dmem[d_addr[11:2]] = d_wdata;
                end else if (d_req) begin
                    d_rdata <= dmem[d_addr[11:2]];
                end
                d_wait = -1;
            end else begin
                d_wait--;
            end
        end
        if (d_req && !d_ack && d_addr == `CORE_IO_BUS_ADDR) begin
            other_errors++;
            $display("Access to the IO address reached the d port at %0t", $time);
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (io_valid) begin
                if (ebreak_seen) begin
                    other_errors++;
                    $display("io_valid pulse after ebreak at %0t", $time);
                end
                if (io_idx < io_exp.size()) begin
                    check_io(io_data, io_exp[io_idx]);
                end else begin
                    other_errors++;
                    $display("Extra io value %h at %0t beyond the expected list", io_data, $time);
                end
                io_idx++;
            end
            if (ebreak_seen && !ebreak) begin
                other_errors++;
                $display("ebreak dropped at %0t", $time);
            end
            if (ebreak_seen && i_req && !i_req_prev) begin
                other_errors++;
                $display("New instruction fetch after ebreak at %0t", $time);
            end
            ebreak_seen = ebreak_seen || ebreak;
        end
        i_req_prev = i_req;
    end

    always @(posedge clk) begin
        cycles++;
        if (timeout_limit > 0 && cycles >= timeout_limit) begin
            $display("Timeout after %0d cycles without ebreak", cycles);
            $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        i_ack = 1'b0;
        i_rdata = '0;
        d_ack = 1'b0;
        d_rdata = '0;
        io_idx = 0;
        mismatches = 0;
        other_errors = 0;
        cycles = 0;
        timeout_limit = 0;
        i_wait = -1;
        d_wait = -1;
        ebreak_seen = 1'b0;
        i_req_prev = 1'b0;
        void'($urandom(25));
        load_golden();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        while (!ebreak) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);
        if (io_idx < io_exp.size()) begin
            other_errors++;
            $display("Missing io values: saw %0d of %0d", io_idx, io_exp.size());
        end
        foreach (final_addr[k]) begin
            check_mem(final_addr[k], dmem[final_addr[k][11:2]], final_exp[k]);
        end
        $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* scalar_core_golden.txt */
// Header: program length, data pair count, io count, final pair count
// Then program words, data pairs (addr value), io values, final pairs (addr value)
16 2 8 3
// Program
0C400005 // ADDI r1, r0, 5
0C83FFFD // ADDI r2, r0, -3
04C48000 // ADD  r3, r1, r2
14C00FFC // SW   r3, io
09084000 // SUB  r4, r2, r1
15000FFC // SW   r4, io
0D400100 // ADDI r5, r0, 0x100
14540000 // SW   r1, 0(r5)
11940004 // LW   r6, 4(r5)
0DC00009 // ADDI r7, r0, 9
06184000 // ADD  r8, r6, r1
15C00FFC // SW   r7, io
16000FFC // SW   r8, io
12540000 // LW   r9, 0(r5)
16400FFC // SW   r9, io
0E800003 // ADDI r10, r0, 3
16800FFC // SW   r10, io
0EABFFFF // ADDI r10, r10, -1
1A83FFFE // BNE  r10, r0, -2
16140008 // SW   r8, 8(r5)
FC000000 // EBREAK
14400FFC // SW   r1, io
// Initial data
00000104 12345678
00000108 DEADBEEF
// Expected io values
00000002 FFFFFFF8 00000009 1234567D 00000005 00000003 00000002 00000001
// Expected final data
00000100 00000005
00000104 12345678
00000108 1234567D

/* scalar_core.f */
+incdir+.
mem_pkg.sv
isa_pkg.sv
core_ifs.sv
front_end.sv
scheduler.sv
back_end.sv
mem_ctrl.sv
scalar_core.sv
scalar_core_checker.sv
scalar_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f scalar_core.f \
    --top-module scalar_core_tb -o scalar_core_sim

./obj_dir/scalar_core_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
